// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - design/fetch_pkg.sv
  - design/inst_slot_if.sv
  - design/fetch_ctrl.sv
  - design/fetch_pc_counter.sv
  - design/line_buffer.sv
  - design/predecoder.sv
  - design/fetch_frontend.sv
  - target: test
    files:
      - test/fetch_frontend_checker.sv
      - test/fetch_frontend_tb.sv

// ==== design/fetch_ctrl.sv ====
// fetch sequencing FSM: line request strobe, response wait, decode until redirect or line end
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl import fetch_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic ic_resp,
    input  logic line_done,
    input  logic redirect,
    output logic ic_req,
    output logic line_load
);

    fetch_state_e state_q;
    fetch_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fs_request: begin
                state_d = fs_wait;  // strobe lasts one cycle
            end
            fs_wait: begin
                if (ic_resp) begin
                    state_d = fs_decode;
                end
            end
            fs_decode: begin
                if (redirect || line_done) begin
                    state_d = fs_request;
                end
            end
            default: begin
                state_d = fs_request;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= fs_request;  // first request right after reset
        end else begin
            state_q <= state_d;
        end
    end

    // no request while held in reset
    assign ic_req = (state_q == fs_request) && !rst;

    // a response is only taken while one is outstanding
    assign line_load = (state_q == fs_wait) && ic_resp;

endmodule

`default_nettype wire

// ==== design/fetch_frontend.sv ====
// fetch frontend top: FSM, PC counter, line buffer and pre-decoder joined by the slot interface
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend import fetch_pkg::*; #(
    parameter int    LINE_HW  = 4,
    parameter addr_t RESET_PC = 32'h0000_1000
) (
    input  logic                           clk,
    input  logic                           rst,
    output logic                           ic_req,
    output addr_t                          ic_addr,
    input  logic                           ic_resp,
    input  logic [LINE_HW-1:0][HALF_W-1:0] ic_rdat,
    output logic                           inst_valid,
    output addr_t                          inst_pc,
    output inst_t                          inst_ir,
    output inst_kind_e                     inst_kind,
    output logic                           inst_call,
    output logic                           inst_ret,
    output addr_t                          inst_target
);

    logic  line_load;
    logic  line_done;
    logic  redirect;
    addr_t redirect_pc;
    addr_t fetch_pc;

    inst_slot_if slot_if ();

    fetch_ctrl ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .ic_resp   (ic_resp),
        .line_done (line_done),
        .redirect  (redirect),
        .ic_req    (ic_req),
        .line_load (line_load)
    );

    fetch_pc_counter #(
        .LINE_HW  (LINE_HW),
        .RESET_PC (RESET_PC)
    ) pc_i (
        .clk         (clk),
        .rst         (rst),
        .line_done   (line_done),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_pc    (fetch_pc),
        .ic_addr     (ic_addr)
    );

    line_buffer #(
        .LINE_HW (LINE_HW)
    ) lbuf_i (
        .clk       (clk),
        .rst       (rst),
        .line_load (line_load),
        .ic_rdat   (ic_rdat),
        .fetch_pc  (fetch_pc),
        .redirect  (redirect),
        .slot      (slot_if.source),
        .line_done (line_done)
    );

    predecoder pdec_i (
        .slot        (slot_if.sink),
        .inst_valid  (inst_valid),
        .inst_pc     (inst_pc),
        .inst_ir     (inst_ir),
        .inst_kind   (inst_kind),
        .inst_call   (inst_call),
        .inst_ret    (inst_ret),
        .inst_target (inst_target),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== design/fetch_pc_counter.sv ====
// fetch PC register with line advance and redirect load, plus line-aligned cache address
`timescale 1ns/100ps
`default_nettype none

module fetch_pc_counter import fetch_pkg::*; #(
    parameter int    LINE_HW  = 4,
    parameter addr_t RESET_PC = 32'h0000_1000
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  line_done,
    input  logic  redirect,
    input  addr_t redirect_pc,
    output addr_t fetch_pc,
    output addr_t ic_addr
);

    localparam int OFF_W = $clog2(LINE_HW) + 1;  // byte offset bits inside a line

    addr_t pc_q;       // exact PC, low bits pick the entry parcel
    addr_t line_base;

    assign line_base = {pc_q[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (redirect) begin
            pc_q <= redirect_pc;  // wins over line end
        end else if (line_done) begin
            pc_q <= line_base + addr_t'(2 * LINE_HW);  // next sequential line
        end
    end

    assign fetch_pc = pc_q;
    assign ic_addr  = line_base;

endmodule

`default_nettype wire

// ==== design/fetch_pkg.sv ====
// shared widths, address and instruction types, fetch enums, opcode and link register constants
`default_nettype none

package fetch_pkg;

    localparam int ADDR_W = 32;  // byte address
    localparam int HALF_W = 16;  // one parcel
    localparam int INST_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [HALF_W-1:0] half_t;
    typedef logic [INST_W-1:0] inst_t;  // upper half zero for compressed

    // what the pre-decoder makes of an instruction
    typedef enum logic [1:0] {
        ik_other  = 2'd0,
        ik_branch = 2'd1,  // conditional, incl. c.beqz/c.bnez
        ik_jal    = 2'd2,  // jal and c.j
        ik_jalr   = 2'd3   // jalr, c.jr, c.jalr
    } inst_kind_e;

    typedef enum logic [1:0] {
        fs_request = 2'd0,  // request strobe
        fs_wait    = 2'd1,  // line in flight
        fs_decode  = 2'd2   // draining the line
    } fetch_state_e;

    // major opcodes, bits 6:0
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // link registers for call/return hints
    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

endpackage

`default_nettype wire

// ==== design/inst_slot_if.sv ====
// interface carrying one extracted instruction from the line buffer to the pre-decoder
`timescale 1ns/100ps
`default_nettype none

interface inst_slot_if import fetch_pkg::*; ();

    logic  slot_valid;  // one strobe per instruction
    addr_t slot_pc;
    inst_t slot_ir;
    logic  slot_comp;   // 16-bit form

    modport source (
        output slot_valid,
        output slot_pc,
        output slot_ir,
        output slot_comp
    );

    modport sink (
        input slot_valid,
        input slot_pc,
        input slot_ir,
        input slot_comp
    );

endinterface

`default_nettype wire

// ==== design/line_buffer.sv ====
// line holding register with parcel cursor, cross-line carry and one-per-cycle instruction split
`timescale 1ns/100ps
`default_nettype none

module line_buffer import fetch_pkg::*; #(
    parameter int LINE_HW = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          line_load,
    input  logic [LINE_HW-1:0][HALF_W-1:0] ic_rdat,
    input  addr_t                         fetch_pc,
    input  logic                          redirect,
    inst_slot_if.source                   slot,
    output logic                          line_done
);

    localparam int IDX_W = $clog2(LINE_HW);
    localparam int CUR_W = IDX_W + 1;  // cursor can reach LINE_HW
    localparam int OFF_W = IDX_W + 1;

    half_t [LINE_HW-1:0] line_q;
    logic                valid_q;
    logic [CUR_W-1:0]    cur_q;
    half_t               carry_q;        // low half of a straddling instruction
    logic                carry_valid_q;

    logic [IDX_W-1:0] idx_lo;
    logic [IDX_W-1:0] idx_hi;
    half_t            hw_lo;
    half_t            hw_hi;
    addr_t            line_base;
    logic             complete;       // a whole instruction sits at the cursor
    logic [CUR_W-1:0] adv;
    logic [CUR_W-1:0] cur_next;
    logic             tail_start;
    logic             tail_left;      // only a 32-bit start remains

    assign idx_lo     = cur_q[IDX_W-1:0];
    assign idx_hi     = idx_lo + IDX_W'(1);  // wraps, unused at the last parcel
    assign hw_lo      = line_q[idx_lo];
    assign hw_hi      = line_q[idx_hi];
    assign line_base  = {fetch_pc[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign tail_start = line_q[LINE_HW-1][1:0] == 2'b11;

    always_comb begin
        complete       = 1'b1;
        adv            = CUR_W'(1);
        slot.slot_comp = 1'b0;
        slot.slot_ir   = {hw_hi, hw_lo};
        slot.slot_pc   = line_base + addr_t'({cur_q, 1'b0});
        if (carry_valid_q) begin
            // upper half is parcel 0 of this line
            slot.slot_ir = {line_q[0], carry_q};
            slot.slot_pc = line_base - addr_t'(2);
        end else if (hw_lo[1:0] != 2'b11) begin
            slot.slot_comp = 1'b1;
            slot.slot_ir   = {{HALF_W{1'b0}}, hw_lo};
        end else if (cur_q == CUR_W'(LINE_HW - 1)) begin
            complete = 1'b0;  // straddles into the next line
        end else begin
            adv = CUR_W'(2);
        end
    end

    assign cur_next  = cur_q + adv;
    assign tail_left = !complete || (cur_next == CUR_W'(LINE_HW - 1) && tail_start);

    assign slot.slot_valid = valid_q && complete;
    assign line_done       = valid_q && ((complete && cur_next == CUR_W'(LINE_HW)) || tail_left);

    always_ff @(posedge clk) begin
        if (line_load) begin
            line_q <= ic_rdat;
        end
        if (valid_q && tail_left) begin
            carry_q <= line_q[LINE_HW-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q       <= 1'b0;
            cur_q         <= '0;
            carry_valid_q <= 1'b0;
        end else if (redirect) begin
            valid_q       <= 1'b0;  // rest of the line is off path
            carry_valid_q <= 1'b0;
        end else if (line_load) begin
            valid_q <= 1'b1;
            cur_q   <= {1'b0, fetch_pc[OFF_W-1:1]};  // entry parcel
        end else if (valid_q) begin
            cur_q <= cur_next;
            if (line_done) begin
                valid_q <= 1'b0;
            end
            if (carry_valid_q) begin
                carry_valid_q <= 1'b0;  // carried instruction went out
            end
            if (tail_left) begin
                carry_valid_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/predecoder.sv ====
// instruction classifier with call/return hints, target compute and static jump/branch redirect
`timescale 1ns/100ps
`default_nettype none

module predecoder import fetch_pkg::*; (
    inst_slot_if.sink slot,
    output logic       inst_valid,
    output addr_t      inst_pc,
    output inst_t      inst_ir,
    output inst_kind_e inst_kind,
    output logic       inst_call,
    output logic       inst_ret,
    output addr_t      inst_target,
    output logic       redirect,
    output addr_t      redirect_pc
);

    inst_t      ir;
    logic [6:0] opc;
    logic [4:0] rd;       // also rs1 of c.jr/c.jalr
    logic [4:0] rs1;
    addr_t      imm_b;
    addr_t      imm_j;
    addr_t      imm_i;
    addr_t      imm_cj;
    addr_t      imm_cb;
    logic       c_j;
    logic       c_br;
    logic       c_jr;
    logic       rd_link;
    logic       rs1_link;
    logic       back;     // negative offset

    assign ir  = slot.slot_ir;
    assign opc = ir[6:0];
    assign rd  = ir[11:7];
    assign rs1 = ir[19:15];

    assign imm_b  = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_j  = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
    assign imm_i  = {{20{ir[31]}}, ir[31:20]};
    assign imm_cj = {{20{ir[12]}}, ir[12], ir[8], ir[10:9], ir[6], ir[7], ir[2], ir[11],
                     ir[5:3], 1'b0};
    assign imm_cb = {{23{ir[12]}}, ir[12], ir[6:5], ir[2], ir[11:10], ir[4:3], 1'b0};

    // compressed control transfers, quadrants 1 and 2
    assign c_j  = ir[15:13] == 3'b101 && ir[1:0] == 2'b01;
    assign c_br = ir[15:14] == 2'b11 && ir[1:0] == 2'b01;
    assign c_jr = ir[15:13] == 3'b100 && ir[1:0] == 2'b10 && ir[6:2] == 5'd0;

    assign rd_link  = rd == REG_RA || rd == REG_T0;
    assign rs1_link = rs1 == REG_RA || rs1 == REG_T0;

    always_comb begin
        inst_kind   = ik_other;
        inst_call   = 1'b0;
        inst_ret    = 1'b0;
        back        = 1'b0;
        inst_target = slot.slot_pc + (slot.slot_comp ? addr_t'(2) : addr_t'(4));
        if (slot.slot_comp) begin
            if (c_j) begin
                inst_kind   = ik_jal;
                inst_target = slot.slot_pc + imm_cj;
            end else if (c_br) begin
                inst_kind   = ik_branch;
                inst_target = slot.slot_pc + imm_cb;
                back        = ir[12];
            end else if (c_jr) begin
                inst_kind   = ik_jalr;
                inst_target = '0;  // register value not known here
                inst_call   = ir[12];
                inst_ret    = (rd == REG_RA && !ir[12]) || rd == REG_T0;
            end
        end else begin
            case (opc)
                OPC_BRANCH: begin
                    inst_kind   = ik_branch;
                    inst_target = slot.slot_pc + imm_b;
                    back        = ir[31];
                end
                OPC_JAL: begin
                    inst_kind   = ik_jal;
                    inst_target = slot.slot_pc + imm_j;
                    inst_call   = rd_link;
                end
                OPC_JALR: begin
                    inst_kind   = ik_jalr;
                    inst_target = imm_i;  // offset only
                    inst_call   = rd_link;
                    inst_ret    = rs1_link && rs1 != rd;
                end
                default: begin
                    inst_kind = ik_other;
                end
            endcase
        end
    end

    assign inst_valid = slot.slot_valid;
    assign inst_pc    = slot.slot_pc;
    assign inst_ir    = ir;

    // jumps always, branches only backwards
    assign redirect    = slot.slot_valid &&
                         (inst_kind == ik_jal || (inst_kind == ik_branch && back));
    assign redirect_pc = inst_target;

endmodule

`default_nettype wire

// ==== tb.f ====
design/fetch_pkg.sv
design/inst_slot_if.sv
design/fetch_ctrl.sv
design/fetch_pc_counter.sv
design/line_buffer.sv
design/predecoder.sv
design/fetch_frontend.sv
test/fetch_frontend_checker.sv
test/fetch_frontend_tb.sv

// ==== test/fetch_frontend_checker.sv ====
// concurrent assertions on the fetch frontend request and instruction strobes, with bind
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend_checker (
    input wire logic clk,
    input wire logic rst,
    input wire logic ic_req,
    input wire logic ic_resp,
    input wire logic inst_valid
);

    logic pending_q;  // a request waits for its line

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else if (ic_req) begin
            pending_q <= 1'b1;
        end else if (ic_resp) begin
            pending_q <= 1'b0;
        end
    end

    a_req_single: assert property (@(posedge clk) disable iff (rst) ic_req |=> !ic_req)
        else $error("ic_req held for two cycles");

    a_no_inst_on_req: assert property (@(posedge clk) disable iff (rst) !(ic_req && inst_valid))
        else $error("inst_valid in a request cycle");

    a_one_outstanding: assert property (@(posedge clk) disable iff (rst) ic_req |-> !pending_q)
        else $error("second ic_req before the response");

endmodule

bind fetch_frontend fetch_frontend_checker checker_i (
    .clk        (clk),
    .rst        (rst),
    .ic_req     (ic_req),
    .ic_resp    (ic_resp),
    .inst_valid (inst_valid)
);

`default_nettype wire

// ==== test/fetch_frontend_tb.sv ====
// testbench for the fetch frontend: clock, reset, line memory model, reference decoder and checks
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend_tb import fetch_pkg::*; ();

    localparam int    LINE_HW  = 4;
    localparam addr_t RESET_PC = 32'h0000_1000;
    localparam int    N_INST   = 2000;
    localparam int    TIMEOUT  = 200;

    logic                           clk;
    logic                           rst;
    logic                           ic_req;
    addr_t                          ic_addr;
    logic                           ic_resp;
    logic [LINE_HW-1:0][HALF_W-1:0] ic_rdat;
    logic                           inst_valid;
    addr_t                          inst_pc;
    inst_t                          inst_ir;
    inst_kind_e                     inst_kind;
    logic                           inst_call;
    logic                           inst_ret;
    addr_t                          inst_target;

    half_t       mem [0:4095];  // indexed by address bits 12:1
    logic [31:0] lcg_state;
    int          errors;
    int          checked;

    fetch_frontend #(
        .LINE_HW  (LINE_HW),
        .RESET_PC (RESET_PC)
    ) dut_i (
        .clk         (clk),
        .rst         (rst),
        .ic_req      (ic_req),
        .ic_addr     (ic_addr),
        .ic_resp     (ic_resp),
        .ic_rdat     (ic_rdat),
        .inst_valid  (inst_valid),
        .inst_pc     (inst_pc),
        .inst_ir     (inst_ir),
        .inst_kind   (inst_kind),
        .inst_call   (inst_call),
        .inst_ret    (inst_ret),
        .inst_target (inst_target)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic place16(input addr_t a, input half_t h);
        mem[a[12:1]] = h;
    endtask

    task automatic place32(input addr_t a, input inst_t w);
        place16(a, w[15:0]);
        place16(a + addr_t'(2), w[31:16]);
    endtask

    // expected decode of the instruction at pc, returns the next fetch PC
    function automatic addr_t ref_inst(input addr_t pc, output inst_t ir,
                                       output inst_kind_e kind, output logic call,
                                       output logic ret, output addr_t target,
                                       output logic redir);
        addr_t      pc_hi;
        half_t      lo;
        half_t      hi;
        logic       comp;
        logic [4:0] rd;
        logic [4:0] rs1;
        addr_t      imm;
        pc_hi  = pc + addr_t'(2);
        lo     = mem[pc[12:1]];
        hi     = mem[pc_hi[12:1]];
        comp   = lo[1:0] != 2'b11;
        ir     = comp ? {16'h0000, lo} : {hi, lo};
        kind   = ik_other;
        call   = 1'b0;
        ret    = 1'b0;
        redir  = 1'b0;
        target = pc + (comp ? addr_t'(2) : addr_t'(4));
        rd     = ir[11:7];
        rs1    = ir[19:15];
        if (comp) begin
            if (lo[1:0] == 2'b01 && lo[15:13] == 3'b101) begin  // c.j
                imm    = {{20{lo[12]}}, lo[12], lo[8], lo[10:9], lo[6], lo[7], lo[2], lo[11],
                          lo[5:3], 1'b0};
                kind   = ik_jal;
                target = pc + imm;
                redir  = 1'b1;
            end else if (lo[1:0] == 2'b01 && lo[15:14] == 2'b11) begin  // c.beqz, c.bnez
                imm    = {{23{lo[12]}}, lo[12], lo[6:5], lo[2], lo[11:10], lo[4:3], 1'b0};
                kind   = ik_branch;
                target = pc + imm;
                redir  = lo[12];
            end else if (lo[1:0] == 2'b10 && lo[15:13] == 3'b100 && lo[6:2] == 5'd0) begin
                kind   = ik_jalr;
                target = '0;
                call   = lo[12];
                ret    = (rd == 5'd1 && !lo[12]) || rd == 5'd5;
            end
        end else begin
            case (ir[6:0])
                7'b1100011: begin
                    imm    = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
                    kind   = ik_branch;
                    target = pc + imm;
                    redir  = ir[31];  // backward only
                end
                7'b1101111: begin
                    imm    = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
                    kind   = ik_jal;
                    target = pc + imm;
                    call   = rd == 5'd1 || rd == 5'd5;
                    redir  = 1'b1;
                end
                7'b1100111: begin
                    kind   = ik_jalr;
                    target = {{20{ir[31]}}, ir[31:20]};
                    call   = rd == 5'd1 || rd == 5'd5;
                    ret    = (rs1 == 5'd1 || rs1 == 5'd5) && rs1 != rd;
                end
                default: begin
                    kind = ik_other;
                end
            endcase
        end
        return redir ? target : pc + (comp ? addr_t'(2) : addr_t'(4));
    endfunction

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_inst(input string what, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_kind(input string what, input inst_kind_e got, input inst_kind_e exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("%0d errors in %0d checked instructions", errors, checked);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic wait_req();
        int n;
        n = 0;
        @(posedge clk);
        while (!ic_req) begin
            n++;
            if (n >= TIMEOUT) begin
                abort_run("timeout: the frontend issued no line request for 200 cycles");
            end
            @(posedge clk);
        end
    endtask

    task automatic wait_inst();
        int n;
        n = 0;
        @(posedge clk);
        while (!inst_valid) begin
            n++;
            if (n >= TIMEOUT) begin
                abort_run("timeout: the frontend emitted no instruction for 200 cycles");
            end
            @(posedge clk);
        end
    endtask

    // memory model: one line per request after 1 to 4 cycles
    initial begin
        addr_t       a;
        addr_t       hw_addr;
        int          d;
        logic [31:0] r;
        forever begin
            wait_req();
            a = {ic_addr[31:3], 3'b000};
            r = lcg_next();
            d = 1 + int'(r[17:16]);
            repeat (d) @(negedge clk);
            for (int i = 0; i < LINE_HW; i++) begin
                hw_addr    = a + addr_t'(2 * i);
                ic_rdat[i] = mem[hw_addr[12:1]];
            end
            ic_resp = 1'b1;
            @(negedge clk);
            ic_resp = 1'b0;
        end
    end

    initial begin
        addr_t      exp_pc;
        addr_t      nxt_pc;
        addr_t      e_target;
        inst_t      e_ir;
        inst_kind_e e_kind;
        logic       e_call;
        logic       e_ret;
        logic       e_redir;
        clk       = 1'b0;
        rst       = 1'b1;
        ic_resp   = 1'b0;
        ic_rdat   = '0;
        errors    = 0;
        checked   = 0;
        lcg_state = 32'he1ab4563;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = half_t'(lcg_next() >> 16);
        end
        // fixed program at the reset PC, random words beyond 0x1042
        place16(32'h1000, 16'h0001);        // c.nop
        place32(32'h1002, 32'h0000_0013);   // nop
        place32(32'h1006, 32'h0010_0093);   // addi x1, straddles a line
        place32(32'h100a, 32'h0080_00ef);   // jal x1, +8
        place16(32'h1012, 16'h9082);        // c.jalr x1
        place16(32'h1014, 16'h8082);        // c.jr x1
        place32(32'h1016, 32'h0000_8067);   // jalr x0, 0(x1), straddles
        place32(32'h101a, 32'h0000_1863);   // bne forward, falls through
        place16(32'h101e, 16'ha029);        // c.j +10
        place16(32'h1020, 16'ha801);        // c.j +16
        place16(32'h1028, 16'hdc65);        // c.beqz back to 0x1020
        place16(32'h102a, 16'ha819);        // c.j +22
        place32(32'h1030, 32'hfe00_0de3);   // beq back to 0x102a
        place16(32'h1040, 16'he011);        // c.bnez forward, falls through
        repeat (3) begin
            @(negedge clk);
            check_flag("ic_req in reset", ic_req, 1'b0);
            check_flag("inst_valid in reset", inst_valid, 1'b0);
        end
        rst = 1'b0;
        @(posedge clk);
        check_flag("first ic_req", ic_req, 1'b1);
        check_addr("first ic_addr", ic_addr, {RESET_PC[31:3], 3'b000});
        exp_pc = RESET_PC;
        while (checked < N_INST) begin
            wait_inst();
            nxt_pc = ref_inst(exp_pc, e_ir, e_kind, e_call, e_ret, e_target, e_redir);
            check_addr("inst_pc", inst_pc, exp_pc);
            check_inst("inst_ir", inst_ir, e_ir);
            check_kind("inst_kind", inst_kind, e_kind);
            check_flag("inst_call", inst_call, e_call);
            check_flag("inst_ret", inst_ret, e_ret);
            check_addr("inst_target", inst_target, e_target);
            checked++;
            if (e_redir) begin
                @(posedge clk);  // refetch follows the jump by one cycle
                check_flag("ic_req after redirect", ic_req, 1'b1);
                check_addr("ic_addr after redirect", ic_addr, {e_target[31:3], 3'b000});
            end
            exp_pc = nxt_pc;
        end
        $display("%0d errors in %0d checked instructions", errors, checked);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
